/* src/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

//////////////////////////////
// Datapath width
`define XLEN 32

//////////////////////////////
// Execution units
`define NUM_UNITS 3

// Bit positions inside every unit vector
`define BRANCH_UNIT 0
`define ALU_UNIT 1
`define LS_UNIT 2

// Return address is PC plus one instruction
`define JAL_LINK_OFFSET 4

`endif

/* src/issue_pkg.sv */
`default_nettype none

`include "issue_macros.svh"

package issue_pkg;

    //////////////////////////////
    // Opcodes, bits 6 to 2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    // Function-3 codes that the decode logic looks at
    localparam logic [2:0] ADD_SUB_FN3 = 3'b000;
    localparam logic [2:0] SLT_FN3     = 3'b010;
    localparam logic [2:0] SLTU_FN3    = 3'b011;
    localparam logic [2:0] BLTU_FN3    = 3'b110;
    localparam logic [2:0] BGEU_FN3    = 3'b111;

    //////////////////////////////
    // ALU operand selects
    typedef enum logic [1:0] {
        ALU_RS1_ZERO = 2'b00,
        ALU_RS1_PC   = 2'b01,
        ALU_RS1_RF   = 2'b10
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        ALU_RS2_LUI_AUIPC = 2'b00,
        ALU_RS2_ARITH_IMM = 2'b01,
        ALU_RS2_JAL_JALR  = 2'b10,
        ALU_RS2_RF        = 2'b11
    } alu_rs2_sel_t;

    typedef struct packed {
        alu_rs1_sel_t rs1_sel;
        alu_rs2_sel_t rs2_sel;
    } alu_sel_t;

    typedef logic [`NUM_UNITS-1:0] unit_vec_t;

    //////////////////////////////
    // Fetch and register file
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instruction;
    } fetch_packet_t;

    typedef struct packed {
        logic [4:0] rs1_addr;
        logic [4:0] rs2_addr;
        logic [4:0] rd_addr;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
    } rf_request_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic rs1_conflict;
        logic rs2_conflict;
    } rf_read_t;

    //////////////////////////////
    // Unit packets
    typedef struct packed {
        logic [`XLEN:0] in1;
        logic [`XLEN:0] in2;
        logic subtract;
        logic arith;
        logic [2:0] fn3;
    } alu_inputs_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1;
        logic [11:0] offset;
        logic [31:0] pc;
        logic [2:0] fn3;
        logic load;
        logic store;
        logic store_forward;
    } ls_inputs_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        logic [31:0] pc;
        logic [2:0] fn3;
        logic use_signed;
        logic jal;
        logic jalr;
    } branch_inputs_t;

endpackage

`default_nettype wire

/* src/instr_classifier.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_macros.svh"

module instr_classifier (
    input  issue_pkg::fetch_packet_t fb,
    output issue_pkg::rf_request_t   rf_req,
    output issue_pkg::unit_vec_t     requested,
    output issue_pkg::alu_sel_t      alu_sel,
    output logic                     legal
);

    import issue_pkg::*;

    opcode_t opcode_trim;
    logic    full_width;
    logic    known_opcode;
    logic    mul_div_op;

    //////////////////////////////
    // Instruction fields
    assign opcode_trim = opcode_t'(fb.instruction[6:2]);

    // All supported encodings are 32 bits wide
    assign full_width = (fb.instruction[1:0] == 2'b11);
    assign mul_div_op = fb.instruction[25];

    assign rf_req.rs1_addr = fb.instruction[19:15];
    assign rf_req.rs2_addr = fb.instruction[24:20];
    assign rf_req.rd_addr  = fb.instruction[11:7];

    //////////////////////////////
    // Register usage
    assign rf_req.uses_rs1 = opcode_trim inside {JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH};
    assign rf_req.uses_rs2 = opcode_trim inside {BRANCH, STORE, ARITH};
    assign rf_req.uses_rd  =
        opcode_trim inside {LUI, AUIPC, JAL, JALR, LOAD, ARITH_IMM, ARITH};

    //////////////////////////////
    // Unit requests
    // Jumps need the branch unit for the target and the ALU for the link
    assign requested[`BRANCH_UNIT] = opcode_trim inside {BRANCH, JAL, JALR};
    assign requested[`ALU_UNIT] =
        opcode_trim inside {LUI, AUIPC, ARITH_IMM, ARITH, JAL, JALR};
    assign requested[`LS_UNIT] = opcode_trim inside {LOAD, STORE};

    //////////////////////////////
    // ALU operand selection
    always_comb begin
        case (opcode_trim)
            LUI:              alu_sel.rs1_sel = ALU_RS1_ZERO;
            AUIPC, JAL, JALR: alu_sel.rs1_sel = ALU_RS1_PC;
            default:          alu_sel.rs1_sel = ALU_RS1_RF;
        endcase

        case (opcode_trim)
            LUI, AUIPC: alu_sel.rs2_sel = ALU_RS2_LUI_AUIPC;
            ARITH_IMM:  alu_sel.rs2_sel = ALU_RS2_ARITH_IMM;
            JAL, JALR:  alu_sel.rs2_sel = ALU_RS2_JAL_JALR;
            default:    alu_sel.rs2_sel = ALU_RS2_RF;
        endcase
    end

    //////////////////////////////
    // Legality
    // FENCE and SYSTEM decode but go to no unit
    assign known_opcode = opcode_trim inside
        {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, ARITH_IMM, ARITH, FENCE, SYSTEM};

    // No multiply or divide unit here
    assign legal = full_width & known_opcode & ~((opcode_trim == ARITH) & mul_div_op);

    // Only jumps share units, so two is the most
    always_comb begin
        assert final ($countones(requested) <= 2)
        else $error("instr_classifier: more than two units requested %b", requested);
    end

endmodule

`default_nettype wire

/* src/issue_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_macros.svh"

module issue_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fb_valid,
    input  logic                   issue_hold,
    input  logic                   legal,
    input  issue_pkg::rf_read_t    rf_rd,
    input  issue_pkg::rf_request_t rf_req,
    input  issue_pkg::unit_vec_t   requested,
    input  issue_pkg::unit_vec_t   unit_ready,
    output issue_pkg::unit_vec_t   unit_issue,
    output logic                   pop,
    output logic                   rd_write_issued,
    output logic                   illegal
);

    import issue_pkg::*;

    logic is_store;
    logic rs1_ready;
    logic rs2_ready;
    logic units_ready;
    logic issue_valid;
    logic issued;

    //////////////////////////////
    // Operand readiness
    // Stores are the only load-store requests with no destination
    assign is_store = requested[`LS_UNIT] & ~rf_req.uses_rd;

    assign rs1_ready = ~rf_req.uses_rs1 | ~rf_rd.rs1_conflict;

    // Store data may still be in flight and gets forwarded later
    assign rs2_ready = ~rf_req.uses_rs2 | ~rf_rd.rs2_conflict | is_store;

    // Units that were not asked for do not matter
    assign units_ready = &(unit_ready | ~requested);

    //////////////////////////////
    // Issue decision
    assign issue_valid = fb_valid & ~issue_hold;
    assign issued      = issue_valid & legal & rs1_ready & rs2_ready & units_ready;

    assign unit_issue = {`NUM_UNITS{issued}} & requested;

    // Illegal instructions are dropped without going anywhere
    assign pop     = issued | (issue_valid & ~legal);
    assign illegal = fb_valid & ~legal;

    assign rd_write_issued = issued & rf_req.uses_rd & (rf_req.rd_addr != 5'd0);

    //////////////////////////////
    // Checks
    a_issue_needs_ready: assert property (
        @(posedge clk) disable iff (rst)
        (unit_issue & ~unit_ready) == '0
    ) else $error("issue_control: strobe %b to a unit that is not ready", unit_issue);

    a_no_issue_on_hold: assert property (
        @(posedge clk) disable iff (rst)
        issue_hold |-> (unit_issue == '0)
    ) else $error("issue_control: strobe %b while issue is held", unit_issue);

endmodule

`default_nettype wire

/* src/alu_operand_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_macros.svh"

module alu_operand_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  issue_pkg::fetch_packet_t fb,
    input  issue_pkg::alu_sel_t      alu_sel,
    input  issue_pkg::rf_read_t      rf_rd,
    input  logic                     issue,
    output issue_pkg::alu_inputs_t   alu_inputs,
    output logic                     alu_valid
);

    import issue_pkg::*;

    localparam logic [`XLEN-1:0] LINK_OFFSET = `JAL_LINK_OFFSET;

    opcode_t          opcode_trim;
    logic             arith_op;
    logic [2:0]       fn3;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    alu_inputs_t      next_inputs;

    assign opcode_trim = opcode_t'(fb.instruction[6:2]);
    assign arith_op    = opcode_trim inside {ARITH, ARITH_IMM};

    // Upper immediates and links are plain additions
    assign fn3 = arith_op ? fb.instruction[14:12] : ADD_SUB_FN3;

    //////////////////////////////
    // Operand muxes
    always_comb begin
        case (alu_sel.rs1_sel)
            ALU_RS1_ZERO: rs1_data = '0;
            ALU_RS1_PC:   rs1_data = fb.pc;
            default:      rs1_data = rf_rd.rs1_data;
        endcase

        case (alu_sel.rs2_sel)
            ALU_RS2_LUI_AUIPC: rs2_data = {fb.instruction[31:12], 12'b0};
            ALU_RS2_ARITH_IMM: rs2_data = {{(`XLEN-12){fb.instruction[31]}}, fb.instruction[31:20]};
            ALU_RS2_JAL_JALR:  rs2_data = LINK_OFFSET;
            default:           rs2_data = rf_rd.rs2_data;
        endcase
    end

    // Extra top bit makes signed and unsigned compares one subtraction
    assign next_inputs.in1 = {rs1_data[`XLEN-1] & ~fn3[0], rs1_data};
    assign next_inputs.in2 = {rs2_data[`XLEN-1] & ~fn3[0], rs2_data};

    assign next_inputs.subtract =
        ((opcode_trim == ARITH) & fb.instruction[30] & (fn3 == ADD_SUB_FN3)) |
        (arith_op & (fn3 inside {SLT_FN3, SLTU_FN3}));

    // Bit shifted in on a right shift
    assign next_inputs.arith = rs1_data[`XLEN-1] & fb.instruction[30];
    assign next_inputs.fn3   = fn3;

    //////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (issue) begin
            alu_inputs <= next_inputs;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue;
        end
    end

endmodule

`default_nettype wire

/* src/ls_branch_operand_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_macros.svh"

module ls_branch_operand_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  issue_pkg::fetch_packet_t  fb,
    input  issue_pkg::rf_read_t       rf_rd,
    input  logic                      ls_issue,
    input  logic                      branch_issue,
    output issue_pkg::ls_inputs_t     ls_inputs,
    output logic                      ls_valid,
    output issue_pkg::branch_inputs_t branch_inputs,
    output logic                      branch_valid,
    output logic [`XLEN-1:0]          store_data,
    output logic                      store_issued_with_data
);

    import issue_pkg::*;

    logic [6:0]     opcode;
    opcode_t        opcode_trim;
    logic [2:0]     fn3;
    logic           is_load;
    logic           is_store;
    ls_inputs_t     next_ls;
    branch_inputs_t next_branch;

    assign opcode      = fb.instruction[6:0];
    assign opcode_trim = opcode_t'(opcode[6:2]);
    assign fn3         = fb.instruction[14:12];

    assign is_load  = (opcode_trim == LOAD);
    assign is_store = (opcode_trim == STORE);

    //////////////////////////////
    // Load-store packet
    // Opcode bit 5 tells the S-type offset from the I-type one
    assign next_ls.offset = opcode[5] ? {fb.instruction[31:25], fb.instruction[11:7]}
                                      : fb.instruction[31:20];
    assign next_ls.rs1   = rf_rd.rs1_data;
    assign next_ls.pc    = fb.pc;
    assign next_ls.fn3   = fn3;
    assign next_ls.load  = is_load;
    assign next_ls.store = is_store;

    // Store data still in flight comes from the forwarding path
    assign next_ls.store_forward = is_store & rf_rd.rs2_conflict;

    //////////////////////////////
    // Branch packet
    assign next_branch.rs1        = rf_rd.rs1_data;
    assign next_branch.rs2        = rf_rd.rs2_data;
    assign next_branch.pc         = fb.pc;
    assign next_branch.fn3        = fn3;
    assign next_branch.use_signed = !(fn3 inside {BLTU_FN3, BGEU_FN3});

    // JAL has opcode bit 3 set, JALR has only bit 2
    assign next_branch.jal  = opcode[3];
    assign next_branch.jalr = ~opcode[3] & opcode[2];

    //////////////////////////////
    // Output registers
    always_ff @(posedge clk) begin
        if (ls_issue) begin
            ls_inputs  <= next_ls;
            store_data <= rf_rd.rs2_data;
        end
        if (branch_issue) begin
            branch_inputs <= next_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ls_valid               <= 1'b0;
            branch_valid           <= 1'b0;
            store_issued_with_data <= 1'b0;
        end else begin
            ls_valid               <= ls_issue;
            branch_valid           <= branch_issue;
            store_issued_with_data <= ls_issue & is_store & ~rf_rd.rs2_conflict;
        end
    end

    a_load_xor_store: assert property (
        @(posedge clk) disable iff (rst)
        ls_valid |-> !(ls_inputs.load && ls_inputs.store)
    ) else $error("ls_branch_operand_gen: packet marked as both load and store");

endmodule

`default_nettype wire

/* src/decode_issue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_macros.svh"

module decode_issue (
    input  logic                      clk,
    input  logic                      rst,

    // Fetch side
    input  logic                      fb_valid,
    input  issue_pkg::fetch_packet_t  fb,
    output logic                      pop,

    // Register file
    output issue_pkg::rf_request_t    rf_req,
    input  issue_pkg::rf_read_t       rf_rd,
    output logic                      rd_write_issued,

    // Unit handshake levels and strobes
    input  issue_pkg::unit_vec_t      unit_ready,
    output issue_pkg::unit_vec_t      unit_issue,
    input  logic                      issue_hold,
    output logic                      illegal,

    // Registered unit packets
    output issue_pkg::alu_inputs_t    alu_inputs,
    output logic                      alu_valid,
    output issue_pkg::ls_inputs_t     ls_inputs,
    output logic                      ls_valid,
    output issue_pkg::branch_inputs_t branch_inputs,
    output logic                      branch_valid,
    output logic [`XLEN-1:0]          store_data,
    output logic                      store_issued_with_data
);

    import issue_pkg::*;

    unit_vec_t requested;
    alu_sel_t  alu_sel;
    logic      legal;

    //////////////////////////////
    // Decode
    instr_classifier u_instr_classifier (
        .fb        (fb),
        .rf_req    (rf_req),
        .requested (requested),
        .alu_sel   (alu_sel),
        .legal     (legal)
    );

    //////////////////////////////
    // Issue
    issue_control u_issue_control (
        .clk             (clk),
        .rst             (rst),
        .fb_valid        (fb_valid),
        .issue_hold      (issue_hold),
        .legal           (legal),
        .rf_rd           (rf_rd),
        .rf_req          (rf_req),
        .requested       (requested),
        .unit_ready      (unit_ready),
        .unit_issue      (unit_issue),
        .pop             (pop),
        .rd_write_issued (rd_write_issued),
        .illegal         (illegal)
    );

    //////////////////////////////
    // Operand packets
    alu_operand_gen u_alu_operand_gen (
        .clk        (clk),
        .rst        (rst),
        .fb         (fb),
        .alu_sel    (alu_sel),
        .rf_rd      (rf_rd),
        .issue      (unit_issue[`ALU_UNIT]),
        .alu_inputs (alu_inputs),
        .alu_valid  (alu_valid)
    );

    ls_branch_operand_gen u_ls_branch_operand_gen (
        .clk                    (clk),
        .rst                    (rst),
        .fb                     (fb),
        .rf_rd                  (rf_rd),
        .ls_issue               (unit_issue[`LS_UNIT]),
        .branch_issue           (unit_issue[`BRANCH_UNIT]),
        .ls_inputs              (ls_inputs),
        .ls_valid               (ls_valid),
        .branch_inputs          (branch_inputs),
        .branch_valid           (branch_valid),
        .store_data             (store_data),
        .store_issued_with_data (store_issued_with_data)
    );

endmodule

`default_nettype wire

/* verification/tb_decode_issue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_macros.svh"

module tb_decode_issue;

    import issue_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int RESET_CYCLES    = 16;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES + 8;

    // Model view of one instruction
    typedef struct packed {
        logic      legal;
        logic      store;
        unit_vec_t req;
        logic      u1;
        logic      u2;
        logic      ud;
    } dec_t;

    logic           clk;
    logic           rst;
    logic           fb_valid;
    fetch_packet_t  fb;
    logic           pop;
    rf_request_t    rf_req;
    rf_read_t       rf_rd;
    logic           rd_write_issued;
    unit_vec_t      unit_ready;
    unit_vec_t      unit_issue;
    logic           issue_hold;
    logic           illegal;
    alu_inputs_t    alu_inputs;
    logic           alu_valid;
    ls_inputs_t     ls_inputs;
    logic           ls_valid;
    branch_inputs_t branch_inputs;
    logic           branch_valid;
    logic [`XLEN-1:0] store_data;
    logic           store_issued_with_data;

    logic [31:0]    lcg_state;
    int             error_count;
    int             check_count;
    int             cycle_count;

    // Expected contents of the output registers
    logic           exp_alu_valid;
    logic           exp_ls_valid;
    logic           exp_branch_valid;
    logic           exp_swd;
    logic           alu_seen;
    logic           ls_seen;
    logic           branch_seen;
    alu_inputs_t    exp_alu;
    ls_inputs_t     exp_ls;
    branch_inputs_t exp_branch;
    logic [31:0]    exp_store_data;

    decode_issue u_decode_issue (
        .clk                    (clk),
        .rst                    (rst),
        .fb_valid               (fb_valid),
        .fb                     (fb),
        .pop                    (pop),
        .rf_req                 (rf_req),
        .rf_rd                  (rf_rd),
        .rd_write_issued        (rd_write_issued),
        .unit_ready             (unit_ready),
        .unit_issue             (unit_issue),
        .issue_hold             (issue_hold),
        .illegal                (illegal),
        .alu_inputs             (alu_inputs),
        .alu_valid              (alu_valid),
        .ls_inputs              (ls_inputs),
        .ls_valid               (ls_valid),
        .branch_inputs          (branch_inputs),
        .branch_valid           (branch_valid),
        .store_data             (store_data),
        .store_issued_with_data (store_issued_with_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Random numbers
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // True about once in n calls, upper bits only
    function automatic logic chance(input int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return ((r >> 16) % n) == 0;
    endfunction

    //////////////////////////////
    // Reference model
    function automatic dec_t decode_model(input logic [31:0] instr);
        dec_t d;
        d = '0;
        d.legal = (instr[1:0] == 2'b11);
        case (opcode_t'(instr[6:2]))
            LUI, AUIPC: begin
                d.req[`ALU_UNIT] = 1'b1;
                d.ud = 1'b1;
            end
            JAL: begin
                d.req[`ALU_UNIT] = 1'b1;
                d.req[`BRANCH_UNIT] = 1'b1;
                d.ud = 1'b1;
            end
            JALR: begin
                d.req[`ALU_UNIT] = 1'b1;
                d.req[`BRANCH_UNIT] = 1'b1;
                d.u1 = 1'b1;
                d.ud = 1'b1;
            end
            BRANCH: begin
                d.req[`BRANCH_UNIT] = 1'b1;
                d.u1 = 1'b1;
                d.u2 = 1'b1;
            end
            LOAD: begin
                d.req[`LS_UNIT] = 1'b1;
                d.u1 = 1'b1;
                d.ud = 1'b1;
            end
            STORE: begin
                d.req[`LS_UNIT] = 1'b1;
                d.store = 1'b1;
                d.u1 = 1'b1;
                d.u2 = 1'b1;
            end
            ARITH_IMM: begin
                d.req[`ALU_UNIT] = 1'b1;
                d.u1 = 1'b1;
                d.ud = 1'b1;
            end
            ARITH: begin
                d.req[`ALU_UNIT] = 1'b1;
                d.u1 = 1'b1;
                d.u2 = 1'b1;
                d.ud = 1'b1;
                // Multiply and divide encodings
                if (instr[25]) begin
                    d.legal = 1'b0;
                end
            end
            FENCE, SYSTEM: d.req = '0;
            default: d.legal = 1'b0;
        endcase
        return d;
    endfunction

    function automatic alu_inputs_t alu_model(input fetch_packet_t f, input rf_read_t r);
        alu_inputs_t a;
        opcode_t     op;
        logic [2:0]  fn3;
        logic [31:0] op1;
        logic [31:0] op2;
        op = opcode_t'(f.instruction[6:2]);
        fn3 = (op == ARITH || op == ARITH_IMM) ? f.instruction[14:12] : 3'b000;
        case (op)
            LUI:              op1 = 32'd0;
            AUIPC, JAL, JALR: op1 = f.pc;
            default:          op1 = r.rs1_data;
        endcase
        case (op)
            LUI, AUIPC: op2 = {f.instruction[31:12], 12'h000};
            ARITH_IMM:  op2 = {{20{f.instruction[31]}}, f.instruction[31:20]};
            JAL, JALR:  op2 = `JAL_LINK_OFFSET;
            default:    op2 = r.rs2_data;
        endcase
        a.in1 = {op1[31] & ~fn3[0], op1};
        a.in2 = {op2[31] & ~fn3[0], op2};
        a.subtract = (op == ARITH && f.instruction[30] && fn3 == 3'b000) ||
                     ((op == ARITH || op == ARITH_IMM) && (fn3 == 3'b010 || fn3 == 3'b011));
        a.arith = op1[31] & f.instruction[30];
        a.fn3 = fn3;
        return a;
    endfunction

    function automatic ls_inputs_t ls_model(input fetch_packet_t f, input rf_read_t r);
        ls_inputs_t l;
        l.store = (opcode_t'(f.instruction[6:2]) == STORE);
        l.load = (opcode_t'(f.instruction[6:2]) == LOAD);
        l.offset = l.store ? {f.instruction[31:25], f.instruction[11:7]} : f.instruction[31:20];
        l.rs1 = r.rs1_data;
        l.pc = f.pc;
        l.fn3 = f.instruction[14:12];
        l.store_forward = l.store & r.rs2_conflict;
        return l;
    endfunction

    function automatic branch_inputs_t branch_model(input fetch_packet_t f, input rf_read_t r);
        branch_inputs_t b;
        b.rs1 = r.rs1_data;
        b.rs2 = r.rs2_data;
        b.pc = f.pc;
        b.fn3 = f.instruction[14:12];
        // BLTU and BGEU are the unsigned compares
        b.use_signed = !(b.fn3 == 3'b110 || b.fn3 == 3'b111);
        b.jal = (opcode_t'(f.instruction[6:2]) == JAL);
        b.jalr = (opcode_t'(f.instruction[6:2]) == JALR);
        return b;
    endfunction

    //////////////////////////////
    // Stimulus
    function automatic logic [31:0] make_instr(input int kind);
        logic [31:0] w;
        logic [31:0] pick;
        opcode_t     op;
        dec_t        d;
        w = next_rand();
        pick = next_rand() >> 20;
        case (kind)
            1: op = pick[0] ? ARITH : ARITH_IMM;
            2: op = pick[1] ? (pick[0] ? JALR : JAL) : (pick[0] ? AUIPC : LUI);
            3: op = pick[0] ? STORE : LOAD;
            4: op = (pick[1:0] == 2'd0) ? JAL : ((pick[1:0] == 2'd1) ? JALR : BRANCH);
            default: begin
                case (pick % 9)
                    0: op = LUI;
                    1: op = AUIPC;
                    2: op = JAL;
                    3: op = JALR;
                    4: op = BRANCH;
                    5: op = LOAD;
                    6: op = STORE;
                    7: op = ARITH_IMM;
                    default: op = ARITH;
                endcase
            end
        endcase
        w[6:0] = {op, 2'b11};
        if (op == ARITH) begin
            w[25] = 1'b0;
        end
        if (kind == 6) begin
            case (pick[3:2])
                2'd0: begin
                    // Opcode outside the supported set
                    d.legal = 1'b1;
                    while (d.legal) begin
                        pick = next_rand();
                        w[6:2] = pick[31:27];
                        d = decode_model(w);
                    end
                end
                2'd1: begin
                    w[6:0] = {ARITH, 2'b11};
                    w[25] = 1'b1;
                end
                2'd2: w[1:0] = {1'b0, pick[4]};
                default: w[6:0] = {pick[4] ? FENCE : SYSTEM, 2'b11};
            endcase
        end
        return w;
    endfunction

    task automatic drive_cycle(input logic [31:0] instr, input logic [31:0] pc_word,
                               input logic heavy);
        logic [31:0] d1;
        logic [31:0] d2;
        unit_vec_t   ready;
        d1 = next_rand();
        d2 = next_rand();
        for (int u = 0; u < `NUM_UNITS; u++) begin
            ready[u] = !chance(heavy ? 2 : 5);
        end
        fb.pc              <= pc_word;
        fb.instruction     <= instr;
        fb_valid           <= !chance(heavy ? 4 : 10);
        issue_hold         <= chance(heavy ? 4 : 10);
        unit_ready         <= ready;
        rf_rd.rs1_data     <= d1;
        rf_rd.rs2_data     <= d2;
        rf_rd.rs1_conflict <= chance(heavy ? 3 : 8);
        rf_rd.rs2_conflict <= chance(heavy ? 3 : 6);
    endtask

    //////////////////////////////
    // Checking
    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // Runs at the falling edge, when inputs and outputs are settled
    task automatic check_cycle(output logic popped);
        dec_t      d;
        logic      open_slot;
        logic      go;
        logic      exp_pop;
        unit_vec_t exp_issue;
        d = decode_model(fb.instruction);
        open_slot = fb_valid && !issue_hold;
        go = open_slot && d.legal &&
             (!d.u1 || !rf_rd.rs1_conflict) &&
             (!d.u2 || !rf_rd.rs2_conflict || d.store) &&
             ((d.req & ~unit_ready) == '0);
        exp_issue = go ? d.req : '0;
        exp_pop = go || (open_slot && !d.legal);

        check_value("pop", pop, exp_pop);
        check_value("unit_issue", unit_issue, exp_issue);
        check_value("illegal", illegal, fb_valid && !d.legal);
        check_value("rd_write_issued", rd_write_issued,
                    go && d.ud && (fb.instruction[11:7] != 5'd0));
        if (fb_valid) begin
            check_value("rf_req", rf_req, {fb.instruction[19:15], fb.instruction[24:20],
                                           fb.instruction[11:7], d.u1, d.u2, d.ud});
        end

        // Registers loaded by the previous cycle's issue
        check_value("alu_valid", alu_valid, exp_alu_valid);
        check_value("ls_valid", ls_valid, exp_ls_valid);
        check_value("branch_valid", branch_valid, exp_branch_valid);
        check_value("store_issued_with_data", store_issued_with_data, exp_swd);
        if (alu_seen) begin
            check_value("alu_inputs", alu_inputs, exp_alu);
        end
        if (ls_seen) begin
            check_value("ls_inputs", ls_inputs, exp_ls);
            check_value("store_data", store_data, exp_store_data);
        end
        if (branch_seen) begin
            check_value("branch_inputs", branch_inputs, exp_branch);
        end

        exp_alu_valid = exp_issue[`ALU_UNIT];
        exp_ls_valid = exp_issue[`LS_UNIT];
        exp_branch_valid = exp_issue[`BRANCH_UNIT];
        exp_swd = exp_issue[`LS_UNIT] && d.store && !rf_rd.rs2_conflict;
        if (exp_issue[`ALU_UNIT]) begin
            exp_alu = alu_model(fb, rf_rd);
            alu_seen = 1'b1;
        end
        if (exp_issue[`LS_UNIT]) begin
            exp_ls = ls_model(fb, rf_rd);
            exp_store_data = rf_rd.rs2_data;
            ls_seen = 1'b1;
        end
        if (exp_issue[`BRANCH_UNIT]) begin
            exp_branch = branch_model(fb, rf_rd);
            branch_seen = 1'b1;
        end
        popped = pop;
    endtask

    task automatic run_test(input int id, input string name, input int count);
        logic [31:0] instr;
        logic [31:0] pc_word;
        logic        popped;
        int          done;
        int          cycles;
        int          errors_before;
        done = 0;
        cycles = 0;
        errors_before = error_count;
        instr = make_instr(id);
        pc_word = next_rand() & 32'hffff_fffc;
        // Fetch holds each instruction until it is popped
        while (done < count) begin
            @(posedge clk);
            drive_cycle(instr, pc_word, id == 5);
            @(negedge clk);
            check_cycle(popped);
            cycles++;
            if (popped) begin
                done++;
                instr = make_instr(id);
                pc_word = next_rand() & 32'hffff_fffc;
            end
        end
        $display("test %0d %s: %0d instructions in %0d cycles, %0d errors",
                 id, name, done, cycles, error_count - errors_before);
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        logic idle_pop;
        lcg_state = 32'h466f;
        error_count = 0;
        check_count = 0;
        rst = 1'b1;
        fb_valid = 1'b0;
        fb = '0;
        rf_rd = '0;
        unit_ready = '0;
        issue_hold = 1'b0;
        exp_alu_valid = 1'b0;
        exp_ls_valid = 1'b0;
        exp_branch_valid = 1'b0;
        exp_swd = 1'b0;
        alu_seen = 1'b0;
        ls_seen = 1'b0;
        branch_seen = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        run_test(1, "alu register and immediate", 60);
        run_test(2, "upper immediates and jumps", 60);
        run_test(3, "loads and stores", 60);
        run_test(4, "branches", 60);
        run_test(5, "hazards and back-pressure", 40);
        run_test(6, "illegal instructions", 60);

        // One idle cycle to see the last packets
        @(posedge clk);
        fb_valid <= 1'b0;
        @(negedge clk);
        check_cycle(idle_pop);

        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, instructions stopped being consumed", cycle_count);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* decode_issue.f */
+incdir+src
src/issue_pkg.sv
src/instr_classifier.sv
src/issue_control.sv
src/alu_operand_gen.sv
src/ls_branch_operand_gen.sv
src/decode_issue.sv
verification/tb_decode_issue.sv

/* Bender.yml */
package:
  name: decode_issue

sources:
  - include_dirs:
      - src
    files:
      - src/issue_pkg.sv
      - src/instr_classifier.sv
      - src/issue_control.sv
      - src/alu_operand_gen.sv
      - src/ls_branch_operand_gen.sv
      - src/decode_issue.sv

  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_decode_issue.sv
